//--- common/cpu_pkg.sv
// Shared core types; opcode encodings cover only the RV32I subset the core implements
`default_nettype none

package cpu_pkg;

  // Data path and address width
  localparam int XLEN = 32;

  // Major opcodes kept by the core, anything else decodes as a no-op
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111
  } opcode_e;

  // ALU operations, pass_b feeds the immediate straight through for LUI
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_e;

  // Conditional branch kinds
  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu
  } branch_e;

  // Request unit sequencing
  typedef enum logic [1:0] {
    ru_idle,
    ru_fetch,
    ru_data,
    ru_done
  } ru_state_e;

endpackage

`default_nettype wire

//--- source/alu.sv
// Purely combinational; flags describe a_i minus b_i when the operation is a subtract
`default_nettype none

module alu (
  input  cpu_pkg::alu_op_e            alu_op_i,
  input  logic [cpu_pkg::XLEN-1:0]    a_i,
  input  logic [cpu_pkg::XLEN-1:0]    b_i,
  output logic [cpu_pkg::XLEN-1:0]    result_o,
  output logic                        zero_o,
  output logic                        negative_o,
  output logic                        carry_o
);

  // One extra bit keeps the borrow and the true signed sign
  logic [cpu_pkg::XLEN:0] udiff;
  logic [cpu_pkg::XLEN:0] sdiff;
  logic [4:0]             shamt;

  assign udiff = {1'b0, a_i} - {1'b0, b_i};
  assign sdiff = {a_i[cpu_pkg::XLEN-1], a_i} - {b_i[cpu_pkg::XLEN-1], b_i};
  assign shamt = b_i[4:0];

  always_comb begin
    unique case (alu_op_i)
      cpu_pkg::alu_add:    result_o = a_i + b_i;
      cpu_pkg::alu_sub:    result_o = udiff[cpu_pkg::XLEN-1:0];
      cpu_pkg::alu_and:    result_o = a_i & b_i;
      cpu_pkg::alu_or:     result_o = a_i | b_i;
      cpu_pkg::alu_xor:    result_o = a_i ^ b_i;
      cpu_pkg::alu_slt:    result_o = {{(cpu_pkg::XLEN-1){1'b0}}, sdiff[cpu_pkg::XLEN]};
      cpu_pkg::alu_sltu:   result_o = {{(cpu_pkg::XLEN-1){1'b0}}, udiff[cpu_pkg::XLEN]};
      cpu_pkg::alu_sll:    result_o = a_i << shamt;
      cpu_pkg::alu_srl:    result_o = a_i >> shamt;
      cpu_pkg::alu_sra:    result_o = $signed(a_i) >>> shamt;
      cpu_pkg::alu_pass_b: result_o = b_i;
      default:             result_o = '0;
    endcase
  end

  assign zero_o = (result_o == '0);

  // Signed less-than for a subtract, plain sign bit otherwise
  assign negative_o = (alu_op_i == cpu_pkg::alu_sub) ? sdiff[cpu_pkg::XLEN]
                                                     : result_o[cpu_pkg::XLEN-1];
  // Borrow out, set when a_i is below b_i unsigned
  assign carry_o = udiff[cpu_pkg::XLEN];

endmodule

`default_nettype wire

//--- decode/control_unit.sv
// Word loads and stores only; funct3 of LW and SW is not checked, unknown opcodes retire as no-ops
`default_nettype none

module control_unit (
  input  logic [31:0]       instr_i,
  output cpu_pkg::alu_op_e  alu_op_o,
  output cpu_pkg::branch_e  branch_o,
  output logic              alu_src_o,
  output logic              use_pc_o,
  output logic              reg_write_o,
  output logic              mem_read_o,
  output logic              mem_write_o,
  output logic              mem_to_reg_o,
  output logic              jump_o,
  output logic              jump_reg_o
);

  cpu_pkg::opcode_e opcode;
  cpu_pkg::alu_op_e arith_op;
  logic [2:0]       funct3;
  logic             bit30;

  assign opcode = cpu_pkg::opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign bit30  = instr_i[30];

  // Arithmetic select shared by OP and OP-IMM
  always_comb begin
    unique case (funct3)
      3'b000:  arith_op = (opcode == cpu_pkg::opc_op && bit30) ? cpu_pkg::alu_sub
                                                               : cpu_pkg::alu_add;
      3'b001:  arith_op = cpu_pkg::alu_sll;
      3'b010:  arith_op = cpu_pkg::alu_slt;
      3'b011:  arith_op = cpu_pkg::alu_sltu;
      3'b100:  arith_op = cpu_pkg::alu_xor;
      3'b101:  arith_op = bit30 ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
      3'b110:  arith_op = cpu_pkg::alu_or;
      default: arith_op = cpu_pkg::alu_and;
    endcase
  end

  always_comb begin
    alu_op_o     = cpu_pkg::alu_add;
    branch_o     = cpu_pkg::br_none;
    alu_src_o    = 1'b0;
    use_pc_o     = 1'b0;
    reg_write_o  = 1'b0;
    mem_read_o   = 1'b0;
    mem_write_o  = 1'b0;
    mem_to_reg_o = 1'b0;
    jump_o       = 1'b0;
    jump_reg_o   = 1'b0;
    unique case (opcode)
      cpu_pkg::opc_op: begin
        alu_op_o    = arith_op;
        reg_write_o = 1'b1;
      end
      cpu_pkg::opc_op_imm: begin
        alu_op_o    = arith_op;
        alu_src_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      cpu_pkg::opc_load: begin
        alu_src_o    = 1'b1;
        reg_write_o  = 1'b1;
        mem_read_o   = 1'b1;
        mem_to_reg_o = 1'b1;
      end
      cpu_pkg::opc_store: begin
        alu_src_o   = 1'b1;
        mem_write_o = 1'b1;
      end
      cpu_pkg::opc_branch: begin
        // Compare through the subtract flags
        alu_op_o = cpu_pkg::alu_sub;
        unique case (funct3)
          3'b000:  branch_o = cpu_pkg::br_eq;
          3'b001:  branch_o = cpu_pkg::br_ne;
          3'b100:  branch_o = cpu_pkg::br_lt;
          3'b101:  branch_o = cpu_pkg::br_ge;
          3'b110:  branch_o = cpu_pkg::br_ltu;
          3'b111:  branch_o = cpu_pkg::br_geu;
          default: branch_o = cpu_pkg::br_none;
        endcase
      end
      cpu_pkg::opc_jal: begin
        jump_o      = 1'b1;
        reg_write_o = 1'b1;
      end
      cpu_pkg::opc_jalr: begin
        alu_src_o   = 1'b1;
        jump_reg_o  = 1'b1;
        reg_write_o = 1'b1;
      end
      cpu_pkg::opc_lui: begin
        alu_op_o    = cpu_pkg::alu_pass_b;
        alu_src_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      cpu_pkg::opc_auipc: begin
        use_pc_o    = 1'b1;
        alu_src_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- decode/immediate_generator.sv
// Format follows the opcode alone; opcodes outside the subset give a zero immediate
`default_nettype none

module immediate_generator (
  input  logic [31:0]                 instr_i,
  output logic [cpu_pkg::XLEN-1:0]    imm_o
);

  cpu_pkg::opcode_e opcode;

  assign opcode = cpu_pkg::opcode_e'(instr_i[6:0]);

  always_comb begin
    unique case (opcode)
      // I type
      cpu_pkg::opc_op_imm,
      cpu_pkg::opc_load,
      cpu_pkg::opc_jalr:   imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
      cpu_pkg::opc_store:  imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
      // B and J carry a hidden zero in bit 0
      cpu_pkg::opc_branch: imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                    instr_i[30:25], instr_i[11:8], 1'b0};
      cpu_pkg::opc_jal:    imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                    instr_i[20], instr_i[30:21], 1'b0};
      cpu_pkg::opc_lui,
      cpu_pkg::opc_auipc:  imm_o = {instr_i[31:12], 12'b0};
      default:             imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- source/register_file.sv
// Write port must be qualified by the retire step outside; x0 writes are dropped here
`default_nettype none

module register_file (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        write_en_i,
  input  logic [4:0]                  rs1_i,
  input  logic [4:0]                  rs2_i,
  input  logic [4:0]                  rd_i,
  input  logic [cpu_pkg::XLEN-1:0]    write_data_i,
  output logic [cpu_pkg::XLEN-1:0]    rs1_data_o,
  output logic [cpu_pkg::XLEN-1:0]    rs2_data_o
);

  logic [cpu_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en_i && rd_i != 5'd0) begin
      regs[rd_i] <= write_data_i;
    end
  end

  // Reads are asynchronous
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

  // x0 holds zero across every write the core attempts
  a_x0_zero: assert property (@(posedge clk) disable iff (reset_i)
    (rs1_i == 5'd0) |-> (rs1_data_o == '0));

endmodule

`default_nettype wire

//--- source/request_unit.sv
// One bus transaction at a time, all four byte lanes; waits on busy with no timeout
`default_nettype none

module request_unit (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        enable_i,
  input  logic [cpu_pkg::XLEN-1:0]    pc_i,
  input  logic                        mem_read_i,
  input  logic                        mem_write_i,
  input  logic [cpu_pkg::XLEN-1:0]    data_adr_i,
  input  logic [cpu_pkg::XLEN-1:0]    store_data_i,
  input  logic [cpu_pkg::XLEN-1:0]    bus_dat_i,
  input  logic                        bus_busy_i,
  output logic [cpu_pkg::XLEN-1:0]    bus_adr_o,
  output logic [cpu_pkg::XLEN-1:0]    bus_dat_o,
  output logic [3:0]                  bus_sel_o,
  output logic                        bus_read_o,
  output logic                        bus_write_o,
  output logic [31:0]                 instr_o,
  output logic [cpu_pkg::XLEN-1:0]    load_data_o,
  output logic                        step_o
);

  cpu_pkg::ru_state_e       state_q;
  logic                     data_pending_q;
  logic [31:0]              instr_q;
  logic [cpu_pkg::XLEN-1:0] load_q;
  logic                     complete;
  logic                     issue_fetch;
  logic                     issue_data;

  // Busy low after the strobe cycle ends the transfer
  assign complete    = !bus_read_o && !bus_write_o && !bus_busy_i;
  assign issue_fetch = (state_q == cpu_pkg::ru_idle) && enable_i;
  assign issue_data  = (state_q == cpu_pkg::ru_data) && !data_pending_q &&
                       (mem_read_i || mem_write_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q        <= cpu_pkg::ru_idle;
      data_pending_q <= 1'b0;
      bus_read_o     <= 1'b0;
      bus_write_o    <= 1'b0;
      instr_q        <= '0;
    end else begin
      // Strobes last a single cycle
      bus_read_o  <= issue_fetch || (issue_data && mem_read_i);
      bus_write_o <= issue_data && mem_write_i;
      unique case (state_q)
        cpu_pkg::ru_idle: begin
          if (issue_fetch) state_q <= cpu_pkg::ru_fetch;
        end
        cpu_pkg::ru_fetch: begin
          if (complete) begin
            instr_q <= bus_dat_i;
            state_q <= cpu_pkg::ru_data;
          end
        end
        cpu_pkg::ru_data: begin
          // First cycle here decodes the latched word
          if (issue_data) begin
            data_pending_q <= 1'b1;
          end else if (!data_pending_q || complete) begin
            data_pending_q <= 1'b0;
            state_q        <= cpu_pkg::ru_done;
          end
        end
        default: state_q <= cpu_pkg::ru_idle;
      endcase
    end
  end

  // Address, write data and load capture
  always_ff @(posedge clk) begin
    if (issue_fetch) begin
      bus_adr_o <= pc_i;
    end else if (issue_data) begin
      bus_adr_o <= data_adr_i;
      bus_dat_o <= store_data_i;
    end
    if (state_q == cpu_pkg::ru_data && data_pending_q && complete && mem_read_i) begin
      load_q <= bus_dat_i;
    end
  end

  assign bus_sel_o   = 4'hf;
  assign instr_o     = instr_q;
  assign load_data_o = load_q;
  assign step_o      = (state_q == cpu_pkg::ru_done);

  a_one_strobe: assert property (@(posedge clk) disable iff (reset_i)
    !(bus_read_o && bus_write_o));

  // Nothing new goes out until the memory drops busy
  a_no_overlap: assert property (@(posedge clk) disable iff (reset_i)
    (bus_read_o || bus_write_o) |=>
      (!(bus_read_o || bus_write_o) until_with !bus_busy_i));

endmodule

`default_nettype wire

//--- source/pc_unit.sv
// Targets are not checked for alignment; JALR only clears bit 0
`default_nettype none

module pc_unit #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        step_i,
  input  cpu_pkg::branch_e            branch_i,
  input  logic                        jump_i,
  input  logic                        jump_reg_i,
  input  logic [cpu_pkg::XLEN-1:0]    imm_i,
  input  logic [cpu_pkg::XLEN-1:0]    alu_result_i,
  input  logic                        zero_i,
  input  logic                        negative_i,
  input  logic                        carry_i,
  output logic [cpu_pkg::XLEN-1:0]    pc_o,
  output logic [cpu_pkg::XLEN-1:0]    pc_plus4_o
);

  logic                     taken;
  logic [cpu_pkg::XLEN-1:0] next_pc;

  // Condition from the subtract flags
  always_comb begin
    unique case (branch_i)
      cpu_pkg::br_eq:  taken = zero_i;
      cpu_pkg::br_ne:  taken = !zero_i;
      cpu_pkg::br_lt:  taken = negative_i;
      cpu_pkg::br_ge:  taken = !negative_i;
      cpu_pkg::br_ltu: taken = carry_i;
      cpu_pkg::br_geu: taken = !carry_i;
      default:         taken = 1'b0;
    endcase
  end

  assign pc_plus4_o = pc_o + 32'd4;

  always_comb begin
    if (jump_reg_i) begin
      next_pc = {alu_result_i[cpu_pkg::XLEN-1:1], 1'b0};
    end else if (jump_i || taken) begin
      next_pc = pc_o + imm_i;
    end else begin
      next_pc = pc_plus4_o;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_o <= RESET_PC;
    end else if (step_i) begin
      pc_o <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- source/cpu_core.sv
// Multi-cycle RV32I subset; no CSRs, traps or sub-word accesses, retire_o marks each instruction
`default_nettype none

module cpu_core #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        enable_i,
  input  logic [cpu_pkg::XLEN-1:0]    bus_dat_i,
  input  logic                        bus_busy_i,
  output logic [cpu_pkg::XLEN-1:0]    bus_adr_o,
  output logic [cpu_pkg::XLEN-1:0]    bus_dat_o,
  output logic [3:0]                  bus_sel_o,
  output logic                        bus_read_o,
  output logic                        bus_write_o,
  output logic                        retire_o,
  output logic [cpu_pkg::XLEN-1:0]    pc_o
);

  logic [31:0]              instr;
  logic [cpu_pkg::XLEN-1:0] load_data, imm, rs1_data, rs2_data;
  logic [cpu_pkg::XLEN-1:0] alu_a, alu_b, alu_result, write_data, pc, pc_plus4;
  logic                     step, zero, negative, carry;

  // Decoded controls
  cpu_pkg::alu_op_e alu_op;
  cpu_pkg::branch_e branch;
  logic alu_src, use_pc, reg_write, mem_read, mem_write, mem_to_reg, jump, jump_reg;

  request_unit ru0 (.clk(clk), .reset_i(reset_i), .enable_i(enable_i), .pc_i(pc),
                    .mem_read_i(mem_read), .mem_write_i(mem_write),
                    .data_adr_i(alu_result), .store_data_i(rs2_data),
                    .bus_dat_i(bus_dat_i), .bus_busy_i(bus_busy_i),
                    .bus_adr_o(bus_adr_o), .bus_dat_o(bus_dat_o), .bus_sel_o(bus_sel_o),
                    .bus_read_o(bus_read_o), .bus_write_o(bus_write_o),
                    .instr_o(instr), .load_data_o(load_data), .step_o(step));

  control_unit cu0 (.instr_i(instr), .alu_op_o(alu_op), .branch_o(branch),
                    .alu_src_o(alu_src), .use_pc_o(use_pc), .reg_write_o(reg_write),
                    .mem_read_o(mem_read), .mem_write_o(mem_write),
                    .mem_to_reg_o(mem_to_reg), .jump_o(jump), .jump_reg_o(jump_reg));

  immediate_generator ig0 (.instr_i(instr), .imm_o(imm));

  // Register write lands only on the retire step
  register_file rf0 (.clk(clk), .reset_i(reset_i), .write_en_i(reg_write && step),
                     .rs1_i(instr[19:15]), .rs2_i(instr[24:20]), .rd_i(instr[11:7]),
                     .write_data_i(write_data),
                     .rs1_data_o(rs1_data), .rs2_data_o(rs2_data));

  // AUIPC takes the PC as first operand
  assign alu_a = use_pc ? pc : rs1_data;
  assign alu_b = alu_src ? imm : rs2_data;

  alu alu0 (.alu_op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .result_o(alu_result),
            .zero_o(zero), .negative_o(negative), .carry_o(carry));

  pc_unit #(.RESET_PC(RESET_PC)) pc0 (
    .clk(clk), .reset_i(reset_i), .step_i(step), .branch_i(branch),
    .jump_i(jump), .jump_reg_i(jump_reg), .imm_i(imm), .alu_result_i(alu_result),
    .zero_i(zero), .negative_i(negative), .carry_i(carry),
    .pc_o(pc), .pc_plus4_o(pc_plus4));

  // Load data, link address or ALU result
  always_comb begin
    if (mem_to_reg) begin
      write_data = load_data;
    end else if (jump || jump_reg) begin
      write_data = pc_plus4;
    end else begin
      write_data = alu_result;
    end
  end

  assign retire_o = step;
  assign pc_o     = pc;

endmodule

`default_nettype wire

//--- tests/bus_memory_model.sv
// 256-word memory behind the core's strobes; address bits above 9 are ignored, no byte lanes
`default_nettype none

module bus_memory_model (
  input  logic        clk,
  input  logic        reset_i,
  input  logic [31:0] delay_pattern_i,
  input  logic [31:0] bus_adr_i,
  input  logic [31:0] bus_dat_i,
  input  logic        bus_read_i,
  input  logic        bus_write_i,
  output logic [31:0] bus_dat_o,
  output logic        bus_busy_o,
  output int          write_count_o,
  output logic [31:0] last_adr_o,
  output logic [31:0] last_dat_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] words [256];
  logic [1:0]  wait_q;
  logic [3:0]  strobe_idx;
  logic [1:0]  lane;

  // Two pattern bits per strobe give a busy time of 1 to 3 cycles
  assign lane = delay_pattern_i[2 * strobe_idx +: 2];

  initial begin
    bus_dat_o     = '0;
    bus_busy_o    = 1'b0;
    write_count_o = 0;
  end

  always @(posedge clk) begin
    if (reset_i) begin
      bus_busy_o    <= 1'b0;
      wait_q        <= '0;
      strobe_idx    <= '0;
      write_count_o <= 0;
    end else if (bus_read_i || bus_write_i) begin
      bus_busy_o <= 1'b1;
      wait_q     <= lane % 2'd3;
      strobe_idx <= strobe_idx + 4'd1;
      if (bus_read_i) begin
        bus_dat_o <= words[bus_adr_i[9:2]];
      end
      // Write log keeps the count and the latest store
      if (bus_write_i) begin
        words[bus_adr_i[9:2]] <= bus_dat_i;
        write_count_o         <= write_count_o + 1;
        last_adr_o            <= bus_adr_i;
        last_dat_o            <= bus_dat_i;
      end
    end else if (wait_q != 2'd0) begin
      wait_q <= wait_q - 2'd1;
    end else begin
      bus_busy_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- tests/cpu_core_tb.sv
// Programs are built at run time from an LCG with seed 6; each ends at its first store
`default_nettype none

module cpu_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] RESET_PC    = 32'h0000_0040;
  localparam logic [31:0] PRELOAD_ADR = 32'h0000_0300;
  localparam logic [31:0] NOP         = 32'h0000_0013;
  localparam logic [31:0] MARK_TAKEN  = 32'h0000_00a5;
  localparam logic [31:0] MARK_FALL   = 32'h0000_005a;
  localparam logic [6:0]  OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0]  OPC_LOAD    = 7'b0000011;
  localparam logic [6:0]  OPC_JALR    = 7'b1100111;
  localparam logic [6:0]  OPC_LUI     = 7'b0110111;
  localparam logic [6:0]  OPC_AUIPC   = 7'b0010111;
  localparam int MAX_ROWS = 32;
  // Worst instruction is two bus transfers at 3 busy cycles plus decode and retire
  localparam int MAX_INSTR_CYCLES = 16;
  localparam int CYCLE_LIMIT = MAX_ROWS * 8 * MAX_INSTR_CYCLES * 2;

  logic        clk;
  logic        reset;
  logic        enable;
  logic [31:0] delay_pattern;
  logic [31:0] mem_rdata;
  logic        mem_busy;
  logic [31:0] bus_adr;
  logic [31:0] bus_wdata;
  logic [3:0]  bus_sel;
  logic        bus_read;
  logic        bus_write;
  logic        retire;
  logic [31:0] pc;
  int          write_count;
  logic [31:0] last_adr;
  logic [31:0] last_dat;

  // Stimulus table with one row per test
  string       row_name   [MAX_ROWS];
  logic [31:0] row_prog   [MAX_ROWS][8];
  logic [31:0] row_adr    [MAX_ROWS];
  logic [31:0] row_dat    [MAX_ROWS];
  logic [31:0] row_pc     [MAX_ROWS];
  logic [31:0] row_pre    [MAX_ROWS];
  logic [31:0] row_delays [MAX_ROWS];
  logic        row_stall  [MAX_ROWS];
  int          num_rows;
  int          slot;

  logic [31:0] lcg_state;
  int          error_count;
  int          failed_tests;
  int          cycle_count = 0;

  cpu_core #(.RESET_PC(RESET_PC)) uut (
    .clk(clk), .reset_i(reset), .enable_i(enable),
    .bus_dat_i(mem_rdata), .bus_busy_i(mem_busy),
    .bus_adr_o(bus_adr), .bus_dat_o(bus_wdata), .bus_sel_o(bus_sel),
    .bus_read_o(bus_read), .bus_write_o(bus_write),
    .retire_o(retire), .pc_o(pc));

  bus_memory_model mem (
    .clk(clk), .reset_i(reset), .delay_pattern_i(delay_pattern),
    .bus_adr_i(bus_adr), .bus_dat_i(bus_wdata),
    .bus_read_i(bus_read), .bus_write_i(bus_write),
    .bus_dat_o(mem_rdata), .bus_busy_o(mem_busy),
    .write_count_o(write_count), .last_adr_o(last_adr), .last_dat_o(last_dat));

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the table", CYCLE_LIMIT);
      $display("Regression failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // RV32I instruction formats
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Register-register op order is add sub and or xor slt sltu sll srl sra
  function automatic logic [31:0] rr_word(input int k, input logic [4:0] rd, rs1, rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    f7 = (k == 1 || k == 9) ? 7'b0100000 : 7'b0000000;
    case (k)
      0, 1:    f3 = 3'b000;
      2:       f3 = 3'b111;
      3:       f3 = 3'b110;
      4:       f3 = 3'b100;
      5:       f3 = 3'b010;
      6:       f3 = 3'b011;
      7:       f3 = 3'b001;
      default: f3 = 3'b101;
    endcase
    return enc_r(f7, rs2, rs1, f3, rd);
  endfunction

  function automatic string rr_name(input int k);
    case (k)
      0:       return "add";
      1:       return "sub";
      2:       return "and";
      3:       return "or";
      4:       return "xor";
      5:       return "slt";
      6:       return "sltu";
      7:       return "sll";
      8:       return "srl";
      default: return "sra";
    endcase
  endfunction

  function automatic logic [31:0] rr_expect(input int k, input logic [31:0] a, b);
    case (k)
      0:       return a + b;
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      5:       return {31'b0, $signed(a) < $signed(b)};
      6:       return {31'b0, a < b};
      7:       return a << b[4:0];
      8:       return a >> b[4:0];
      default: return $signed(a) >>> b[4:0];
    endcase
  endfunction

  // Branch kinds in order beq bne blt bge bltu bgeu
  function automatic logic [2:0] branch_f3(input int kind);
    logic [2:0] codes [6];
    codes = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    return codes[kind];
  endfunction

  function automatic logic branch_expect(input int kind, input logic [31:0] a, b);
    case (kind)
      0:       return a == b;
      1:       return a != b;
      2:       return $signed(a) < $signed(b);
      3:       return $signed(a) >= $signed(b);
      4:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic begin_row(input string name);
    row_name[num_rows] = name;
    for (int i = 0; i < 8; i++) begin
      row_prog[num_rows][i] = NOP;
    end
    row_pre[num_rows]    = '0;
    row_stall[num_rows]  = 1'b0;
    row_delays[num_rows] = lcg_next();
    slot = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    row_prog[num_rows][slot] = word;
    slot++;
  endtask

  // The store that ends a row is the last word emitted
  task automatic end_row(input logic [31:0] adr, input logic [31:0] dat);
    row_adr[num_rows] = adr;
    row_dat[num_rows] = dat;
    row_pc[num_rows]  = RESET_PC + 4 * (slot - 1);
    num_rows++;
  endtask

  // LUI then ADDI with the upper part rounded for the sign of the low twelve bits
  task automatic emit_li(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(enc_u(upper[31:12], rd, OPC_LUI));
    emit(enc_i(value[11:0], rd, 3'b000, rd, OPC_OP_IMM));
  endtask

  task automatic build_table();
    logic [31:0] a, b, imm, tmp;
    int kind;
    for (int k = 0; k < 10; k++) begin
      a = lcg_next();
      b = lcg_next();
      begin_row(rr_name(k));
      emit_li(5'd1, a);
      emit_li(5'd2, b);
      emit(rr_word(k, 5'd3, 5'd1, 5'd2));
      emit(enc_s(12'h200, 5'd3, 5'd0));
      end_row(32'h200, rr_expect(k, a, b));
    end
    a = lcg_next();
    imm = lcg_next();
    begin_row("addi");
    emit_li(5'd1, a);
    emit(enc_i(imm[11:0], 5'd1, 3'b000, 5'd3, OPC_OP_IMM));
    emit(enc_s(12'h200, 5'd3, 5'd0));
    end_row(32'h200, a + {{20{imm[11]}}, imm[11:0]});
    begin_row("srai");
    emit_li(5'd1, a);
    emit(enc_i({7'b0100000, imm[4:0]}, 5'd1, 3'b101, 5'd3, OPC_OP_IMM));
    emit(enc_s(12'h200, 5'd3, 5'd0));
    tmp = $signed(a) >>> imm[4:0];
    end_row(32'h200, tmp);
    begin_row("lui");
    emit(enc_u(imm[31:12], 5'd3, OPC_LUI));
    emit(enc_s(12'h200, 5'd3, 5'd0));
    end_row(32'h200, {imm[31:12], 12'b0});
    begin_row("auipc");
    emit(enc_u(imm[31:12], 5'd3, OPC_AUIPC));
    emit(enc_s(12'h200, 5'd3, 5'd0));
    end_row(32'h200, RESET_PC + {imm[31:12], 12'b0});
    // Second row of a pair flips the outcome with equal or swapped operands
    for (int k = 0; k < 12; k++) begin
      kind = k / 2;
      a = lcg_next();
      b = lcg_next();
      if (a == b) begin
        b = a ^ 32'd1;
      end
      if (k % 2 == 1) begin
        if (kind < 2) begin
          b = a;
        end else begin
          tmp = a;
          a = b;
          b = tmp;
        end
      end
      begin_row($sformatf("branch%0d_%0d", kind, k % 2));
      emit_li(5'd1, a);
      emit_li(5'd2, b);
      emit(enc_i(MARK_TAKEN[11:0], 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
      emit(enc_b(13'd8, 5'd2, 5'd1, branch_f3(kind)));
      emit(enc_i(MARK_FALL[11:0], 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
      emit(enc_s(12'h200, 5'd3, 5'd0));
      end_row(32'h200, branch_expect(kind, a, b) ? MARK_TAKEN : MARK_FALL);
    end
    // Skipped stores go to 0x20c so a missed jump shows as a wrong address
    begin_row("jal");
    emit(enc_j(21'd8, 5'd1));
    emit(enc_s(12'h20c, 5'd0, 5'd0));
    emit(enc_s(12'h200, 5'd1, 5'd0));
    end_row(32'h200, RESET_PC + 32'd4);
    begin_row("jalr");
    emit(enc_u(20'd0, 5'd2, OPC_AUIPC));
    emit(enc_i(12'd17, 5'd2, 3'b000, 5'd5, OPC_JALR));
    emit(enc_s(12'h20c, 5'd0, 5'd0));
    emit(enc_s(12'h20c, 5'd0, 5'd0));
    emit(enc_s(12'h200, 5'd5, 5'd0));
    end_row(32'h200, RESET_PC + 32'd8);
    begin_row("lw_stall");
    row_pre[num_rows]   = lcg_next();
    row_stall[num_rows] = 1'b1;
    emit(enc_i(PRELOAD_ADR[11:0], 5'd0, 3'b010, 5'd5, OPC_LOAD));
    emit(enc_s(12'h304, 5'd5, 5'd0));
    end_row(32'h304, row_pre[num_rows]);
  endtask

  task automatic check_word(input string name, input logic [cpu_pkg::XLEN-1:0] got,
                            input logic [cpu_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic load_memory(input int r);
    logic [31:0] adr;
    for (int i = 0; i < 256; i++) begin
      adr = i * 4;
      mem.words[i] = {~adr[15:0], adr[15:0]};
    end
    for (int i = 0; i < 8; i++) begin
      mem.words[RESET_PC[9:2] + i] = row_prog[r][i];
    end
    mem.words[PRELOAD_ADR[9:2]] = row_pre[r];
  endtask

  task automatic run_row(input int r);
    int errors_before;
    errors_before = error_count;
    @(posedge clk);
    reset         <= 1'b1;
    enable        <= !row_stall[r];
    delay_pattern <= row_delays[r];
    // Memory is idle while reset is seen
    @(posedge clk);
    load_memory(r);
    @(posedge clk);
    reset <= 1'b0;
    if (row_stall[r]) begin
      repeat (6) begin
        @(negedge clk);
        check_bit("bus_read_o", bus_read, 1'b0);
        check_bit("bus_write_o", bus_write, 1'b0);
        check_bit("retire_o", retire, 1'b0);
      end
      @(posedge clk);
      enable <= 1'b1;
    end
    @(negedge clk);
    check_bit("bus_read_o", bus_read, 1'b0);
    check_bit("bus_write_o", bus_write, 1'b0);
    check_word("pc_o", pc, RESET_PC);
    // First fetch one cycle after enable is seen out of reset
    @(negedge clk);
    check_bit("bus_read_o", bus_read, 1'b1);
    check_word("bus_adr_o", bus_adr, RESET_PC);
    check_word("bus_sel_o", {28'b0, bus_sel}, 32'hf);
    while (write_count == 0) begin
      @(negedge clk);
    end
    // PC stays on the store until it retires
    check_word("pc_o", pc, row_pc[r]);
    check_word("bus_adr_o", last_adr, row_adr[r]);
    check_word("bus_dat_o", last_dat, row_dat[r]);
    if (error_count == errors_before) begin
      $display("test %-12s ok", row_name[r]);
    end else begin
      $display("test %-12s FAILED with %0d errors", row_name[r], error_count - errors_before);
      failed_tests++;
    end
  endtask

  initial begin
    lcg_state     = 32'd6;
    reset         = 1'b1;
    enable        = 1'b0;
    delay_pattern = '0;
    error_count   = 0;
    failed_tests  = 0;
    num_rows      = 0;
    build_table();
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("%0d tests run, %0d failed, %0d checks in error",
             num_rows, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
common/cpu_pkg.sv
source/alu.sv
decode/control_unit.sv
decode/immediate_generator.sv
source/register_file.sv
source/request_unit.sv
source/pc_unit.sv
source/cpu_core.sv
tests/bus_memory_model.sv
tests/cpu_core_tb.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - files:
      - common/cpu_pkg.sv
      - source/alu.sv
      - decode/control_unit.sv
      - decode/immediate_generator.sv
      - source/register_file.sv
      - source/request_unit.sv
      - source/pc_unit.sv
      - source/cpu_core.sv
  - target: test
    files:
      - tests/bus_memory_model.sv
      - tests/cpu_core_tb.sv
